// File: tileRenderPkg.sv
package tileRenderPkg;

  // Screen geometry
  localparam logic [3:0] tileSize = 4'd8;
  localparam int lineBits = $clog2(tileSize);
  localparam int mapRows = 10;
  localparam int mapColumns = 20;
  localparam int spriteCount = 6;
  localparam int layerCount = 3;

  localparam logic [9:0] mapTop = 10'd40;
  localparam logic [9:0] mapLeft = 10'd80;
  localparam logic [9:0] mapBottom = 10'(mapTop + mapRows * tileSize - 1);
  localparam logic [9:0] mapRight = 10'(mapLeft + mapColumns * tileSize - 1);

  typedef enum logic [2:0] {
    codeClear,
    codeBlue,
    codeWhite,
    codeCyan,
    codeOrange,
    codeBlack,
    codeGreen,
    codeRed
  } pixelCode;

  typedef enum logic [2:0] {
    spriteRobot,
    spriteCursor,
    spriteTrash,
    spriteEmpty,
    spritePipe,
    spriteGoal
  } spriteId;

  // Leftmost pixel of a row sits in the top slot
  typedef logic [tileSize-1:0][2:0] tileRow;

  // Indexed by pixel code
  localparam logic [23:0] palette [8] = '{
    24'h000000,
    24'h0000FF,
    24'hFFFFFF,
    24'h00FFFF,
    24'hFFA500,
    24'h000000,
    24'h00FF00,
    24'hFF0000
  };

  // Drawing order, last layer ends up on top
  localparam spriteId overlaySprite [layerCount] = '{spriteTrash, spriteRobot, spriteCursor};

  // Sprite file holds 8 rows per sprite, in sprite id order
  localparam string spriteFile = "sprites.mem";
  localparam string mapFile = "map.mem";

endpackage

// File: tileFetch.sv
`timescale 1ns/10ps

module tileFetch
  import tileRenderPkg::*;
(
  input  logic Clock25,
  input  logic rst,
  input  logic [9:0] pixelRow,
  input  logic [9:0] pixelColumn,
  output logic tileValid,
  output tileRow tileData,
  output logic [4:0] tileColumn,
  output logic [3:0] tileRowIndex,
  output logic [2:0] tileLine
);

  // One 3-bit sprite id per cell, row by row
  logic [2:0] mapRom [mapRows * mapColumns];
  tileRow spriteRom [spriteCount * tileSize];

  logic [9:0] rowOffset;
  logic [9:0] colOffset;
  logic inMapRows;
  logic atPrefetch;
  logic [4:0] nextColumn;
  logic [3:0] nextRow;
  logic [2:0] nextLine;
  logic [7:0] mapAddr;
  logic [2:0] cellSprite;

  initial
  begin
    $readmemb(mapFile, mapRom);
    $readmemb(spriteFile, spriteRom);
  end

  assign rowOffset = pixelRow - mapTop;
  // Fetch runs one tile ahead of the column being drawn
  assign colOffset = pixelColumn - (mapLeft - 10'(tileSize));

  assign inMapRows = pixelRow >= mapTop && pixelRow <= mapBottom;
  assign atPrefetch = colOffset < 10'(mapColumns * tileSize) &&
                      colOffset[lineBits-1:0] == '0;

  assign nextColumn = colOffset[lineBits +: 5];
  assign nextRow = rowOffset[lineBits +: 4];
  assign nextLine = rowOffset[lineBits-1:0];

  assign mapAddr = 8'(nextRow * mapColumns + nextColumn);
  assign cellSprite = mapRom[mapAddr];

  always_ff @(posedge Clock25)
  begin
    if (rst)
    begin
      tileValid <= 1'b0;
    end
    else
    begin
      tileValid <= inMapRows && atPrefetch;
    end
  end

  always_ff @(posedge Clock25)
  begin
    if (inMapRows && atPrefetch)
    begin
      tileData <= spriteRom[{cellSprite, nextLine}];
      tileColumn <= nextColumn;
      tileRowIndex <= nextRow;
      tileLine <= nextLine;
    end
  end

endmodule

// File: overlayLayer.sv
`timescale 1ns/10ps

module overlayLayer
  import tileRenderPkg::*;
#(
  parameter int layerIndex = 0
)
(
  input  logic Clock25,
  input  logic rst,
  input  logic inValid,
  input  tileRow inData,
  input  logic [4:0] inColumn,
  input  logic [3:0] inRow,
  input  logic [2:0] inLine,
  input  logic [4:0] objectColumn,
  input  logic [3:0] objectRow,
  output logic outValid,
  output tileRow outData,
  output logic [4:0] outColumn,
  output logic [3:0] outRow,
  output logic [2:0] outLine
);

  localparam spriteId layerSprite = overlaySprite[layerIndex];

  tileRow spriteRom [spriteCount * tileSize];
  tileRow spriteData;
  tileRow mergedData;
  logic objectHere;

  initial
  begin
    $readmemb(spriteFile, spriteRom);
  end

  assign spriteData = spriteRom[{layerSprite, inLine}];

  // A parked object never matches, tiles only span rows 0..9 and columns 0..19
  assign objectHere = objectColumn == inColumn && objectRow == inRow;

  always_comb
  begin
    mergedData = inData;
    if (objectHere)
    begin
      for (int i = 0; i < tileSize; i++)
      begin
        if (spriteData[i] != codeClear)
        begin
          mergedData[i] = spriteData[i];
        end
      end
    end
  end

  always_ff @(posedge Clock25)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= inValid;
    end
  end

  always_ff @(posedge Clock25)
  begin
    outData <= mergedData;
    outColumn <= inColumn;
    outRow <= inRow;
    outLine <= inLine;
  end

endmodule

// File: tilePixelOut.sv
`timescale 1ns/10ps

module tilePixelOut
  import tileRenderPkg::*;
(
  input  logic Clock25,
  input  logic rst,
  input  logic [9:0] pixelRow,
  input  logic [9:0] pixelColumn,
  input  logic inValid,
  input  tileRow inData,
  output logic [23:0] rgb
);

  // Next tile waits in pending until its left edge comes up
  tileRow pendingRow;
  tileRow activeRow;

  logic [9:0] colOffset;
  logic inMap;
  logic tileEdge;
  logic [2:0] pixelSlot;
  logic [2:0] currentCode;

  assign colOffset = pixelColumn - mapLeft;

  assign inMap = pixelRow >= mapTop && pixelRow <= mapBottom &&
                 pixelColumn >= mapLeft && pixelColumn <= mapRight;

  assign tileEdge = colOffset[lineBits-1:0] == '0;
  assign pixelSlot = 3'(tileSize - 1) - colOffset[lineBits-1:0];

  // On the edge the active row still holds the previous tile
  assign currentCode = tileEdge ? pendingRow[pixelSlot] : activeRow[pixelSlot];

  always_ff @(posedge Clock25)
  begin
    if (inValid)
    begin
      pendingRow <= inData;
    end
    if (inMap && tileEdge)
    begin
      activeRow <= pendingRow;
    end
  end

  always_ff @(posedge Clock25)
  begin
    if (rst)
    begin
      rgb <= palette[codeBlack];
    end
    else if (inMap)
    begin
      rgb <= palette[currentCode];
    end
    else
    begin
      rgb <= palette[codeBlack];
    end
  end

endmodule

// File: tileRenderer.sv
`timescale 1ns/10ps

module tileRenderer
  import tileRenderPkg::*;
(
  input  logic Clock25,
  input  logic rst,
  input  logic [9:0] pixelRow,
  input  logic [9:0] pixelColumn,
  input  logic [4:0] objectColumn0,
  input  logic [4:0] objectColumn1,
  input  logic [4:0] objectColumn2,
  input  logic [3:0] objectRow0,
  input  logic [3:0] objectRow1,
  input  logic [3:0] objectRow2,
  output logic [23:0] rgb
);

  // Stage 0 is the fetch output, stage i+1 the output of layer i
  logic stageValid [layerCount+1];
  tileRow stageData [layerCount+1];
  logic [4:0] stageColumn [layerCount+1];
  logic [3:0] stageRow [layerCount+1];
  logic [2:0] stageLine [layerCount+1];

  // Object 0 is trash, 1 robot, 2 cursor
  logic [4:0] objectColumns [layerCount];
  logic [3:0] objectRows [layerCount];

  assign objectColumns[0] = objectColumn0;
  assign objectColumns[1] = objectColumn1;
  assign objectColumns[2] = objectColumn2;
  assign objectRows[0] = objectRow0;
  assign objectRows[1] = objectRow1;
  assign objectRows[2] = objectRow2;

  tileFetch fetch (
    .Clock25(Clock25),
    .rst(rst),
    .pixelRow(pixelRow),
    .pixelColumn(pixelColumn),
    .tileValid(stageValid[0]),
    .tileData(stageData[0]),
    .tileColumn(stageColumn[0]),
    .tileRowIndex(stageRow[0]),
    .tileLine(stageLine[0])
  );

  generate
    for (genvar i = 0; i < layerCount; i++)
    begin : gLayer
      overlayLayer #(
        .layerIndex(i)
      ) layer (
        .Clock25(Clock25),
        .rst(rst),
        .inValid(stageValid[i]),
        .inData(stageData[i]),
        .inColumn(stageColumn[i]),
        .inRow(stageRow[i]),
        .inLine(stageLine[i]),
        .objectColumn(objectColumns[i]),
        .objectRow(objectRows[i]),
        .outValid(stageValid[i+1]),
        .outData(stageData[i+1]),
        .outColumn(stageColumn[i+1]),
        .outRow(stageRow[i+1]),
        .outLine(stageLine[i+1])
      );
    end
  endgenerate

  tilePixelOut pixelOut (
    .Clock25(Clock25),
    .rst(rst),
    .pixelRow(pixelRow),
    .pixelColumn(pixelColumn),
    .inValid(stageValid[layerCount]),
    .inData(stageData[layerCount]),
    .rgb(rgb)
  );

endmodule

// File: tileRenderer_assertions.sv
`timescale 1ns/10ps

module tileRendererAssertions
  import tileRenderPkg::*;
(
  input logic Clock25,
  input logic rst,
  input logic [9:0] pixelRow,
  input logic [9:0] pixelColumn,
  input logic stageValid [layerCount+1],
  input logic [23:0] rgb
);

  logic inMap;
  int failureCount = 0;

  assign inMap = pixelRow >= mapTop && pixelRow <= mapBottom &&
                 pixelColumn >= mapLeft && pixelColumn <= mapRight;

  function automatic logic isPaletteColour(input logic [23:0] colour);
    logic found;
    found = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      if (palette[3'(i)] == colour)
      begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  rgbInPalette: assert property (@(posedge Clock25) disable iff (rst) isPaletteColour(rgb))
    else
    begin
      failureCount++;
      $error("rgb %h is not a palette colour", rgb);
    end

  // Off-map pixels come out black on the next cycle
  outsideBlack: assert property (@(posedge Clock25) disable iff (rst)
    !inMap |=> rgb == 24'h000000)
    else
    begin
      failureCount++;
      $error("rgb not black after an off-map pixel");
    end

  generate
    for (genvar i = 0; i < layerCount; i++)
    begin : gValid
      validFollows: assert property (@(posedge Clock25) disable iff (rst)
        stageValid[i+1] == $past(stageValid[i]))
        else
        begin
          failureCount++;
          $error("layer %0d valid strobe out of step", i);
        end
    end
  endgenerate

endmodule

bind tileRenderer tileRendererAssertions assertions (
  .Clock25(Clock25),
  .rst(rst),
  .pixelRow(pixelRow),
  .pixelColumn(pixelColumn),
  .stageValid(stageValid),
  .rgb(rgb)
);

// File: tileRendererTb.sv
`timescale 1ns/10ps

module tileRendererTb
  import tileRenderPkg::*;
();

  localparam int clockPeriod = 8;
  localparam int resetCycles = 4;
  localparam int resetTimeout = 20;
  localparam int scanFirstRow = int'(mapTop) - 1;
  localparam int scanLastRow = int'(mapBottom) + 1;
  localparam int scanFirstColumn = int'(mapLeft) - 16;
  localparam int scanLastColumn = int'(mapRight) + 8;
  localparam int scanTimeout = 20000;
  localparam logic [23:0] black = 24'h000000;

  logic Clock25;
  logic rst;
  logic [9:0] pixelRow;
  logic [9:0] pixelColumn;
  logic [4:0] objectColumn0;
  logic [4:0] objectColumn1;
  logic [4:0] objectColumn2;
  logic [3:0] objectRow0;
  logic [3:0] objectRow1;
  logic [3:0] objectRow2;
  logic [23:0] rgb;

  int checkCount = 0;
  int errorCount = 0;
  int timeoutCount = 0;

  tileRenderer dut (
    .Clock25(Clock25),
    .rst(rst),
    .pixelRow(pixelRow),
    .pixelColumn(pixelColumn),
    .objectColumn0(objectColumn0),
    .objectColumn1(objectColumn1),
    .objectColumn2(objectColumn2),
    .objectRow0(objectRow0),
    .objectRow1(objectRow1),
    .objectRow2(objectRow2),
    .rgb(rgb)
  );

  initial
  begin
    Clock25 = 1'b0;
    forever
    begin
      #(clockPeriod / 2) Clock25 = ~Clock25;
    end
  end

  initial
  begin
    rst = 1'b1;
    for (int i = 0; i < resetCycles; i++)
    begin
      @(posedge Clock25);
    end
    @(negedge Clock25);
    rst = 1'b0;
  end

  task automatic checkValue(input string name, input logic [23:0] expected,
                            input logic [23:0] actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // One full raster pass with rgb taken one cycle after the probe
  task automatic scanFrame(input logic [9:0] probeRow, input logic [9:0] probeColumn,
                           output logic [23:0] captured, output logic found,
                           output logic timedOut);
    int cycles;
    logic capturePending;
    cycles = 0;
    capturePending = 1'b0;
    captured = black;
    found = 1'b0;
    timedOut = 1'b0;
    for (int r = scanFirstRow; r <= scanLastRow; r++)
    begin
      for (int c = scanFirstColumn; c <= scanLastColumn; c++)
      begin
        @(negedge Clock25);
        if (capturePending)
        begin
          captured = rgb;
          found = 1'b1;
        end
        pixelRow = 10'(r);
        pixelColumn = 10'(c);
        capturePending = 10'(r) == probeRow && 10'(c) == probeColumn;
        cycles++;
        if (cycles > scanTimeout)
        begin
          timedOut = 1'b1;
          return;
        end
      end
    end
    @(negedge Clock25);
    if (capturePending)
    begin
      captured = rgb;
      found = 1'b1;
    end
    pixelRow = '0;
    pixelColumn = '0;
  endtask

  initial
  begin
    int fd;
    int fields;
    int waited;
    int casesRun;
    int assertionCount;
    int tc;
    int tr;
    int rc;
    int rr;
    int cc;
    int cr;
    int pr;
    int pc;
    string line;
    string caseName;
    logic [23:0] expected;
    logic [23:0] captured;
    logic found;
    logic timedOut;

    pixelRow = '0;
    pixelColumn = '0;
    objectColumn0 = 5'd31;
    objectColumn1 = 5'd31;
    objectColumn2 = 5'd31;
    objectRow0 = 4'd15;
    objectRow1 = 4'd15;
    objectRow2 = 4'd15;
    casesRun = 0;

    waited = 0;
    while (rst && waited < resetTimeout)
    begin
      @(negedge Clock25);
      checkValue("duringReset", black, rgb);
      waited++;
    end
    if (rst)
    begin
      $display("Timeout waiting for reset release");
      timeoutCount++;
    end
    else
    begin
      for (int i = 0; i < 2; i++)
      begin
        @(negedge Clock25);
        checkValue("afterReset", black, rgb);
      end

      fd = $fopen("render_cases.txt", "r");
      if (fd == 0)
      begin
        $display("Could not open render_cases.txt");
        errorCount++;
      end
      else
      begin
        while (timeoutCount == 0 && $fgets(line, fd) != 0)
        begin
          if (line.len() > 1 && line.getc(0) != "#")
          begin
            fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d %h", caseName,
                             tc, tr, rc, rr, cc, cr, pr, pc, expected);
            if (fields != 10)
            begin
              $display("Case line could not be parsed: %s", line);
              errorCount++;
            end
            else
            begin
              @(negedge Clock25);
              objectColumn0 = 5'(tc);
              objectRow0 = 4'(tr);
              objectColumn1 = 5'(rc);
              objectRow1 = 4'(rr);
              objectColumn2 = 5'(cc);
              objectRow2 = 4'(cr);
              scanFrame(10'(pr), 10'(pc), captured, found, timedOut);
              casesRun++;
              if (timedOut)
              begin
                $display("Timeout while scanning case %s", caseName);
                timeoutCount++;
              end
              else if (!found)
              begin
                $display("Probe pixel of case %s was never scanned", caseName);
                errorCount++;
              end
              else
              begin
                checkValue(caseName, expected, captured);
              end
            end
          end
        end
        $fclose(fd);
        if (casesRun == 0)
        begin
          $display("No cases were read from render_cases.txt");
          errorCount++;
        end
      end
    end

    assertionCount = dut.assertions.failureCount;
    $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
             checkCount, errorCount, timeoutCount, assertionCount);
    if (errorCount == 0 && timeoutCount == 0 && assertionCount == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: sprites.mem
111_111_111_111_000_000_000_000
111_111_111_111_000_000_000_000
111_111_111_111_000_000_000_000
111_111_111_111_000_000_000_000
111_111_111_111_000_000_000_000
111_111_111_111_000_000_000_000
111_111_111_111_000_000_000_000
111_111_111_111_000_000_000_000
010_010_010_010_010_010_010_010
010_000_000_000_000_000_000_010
010_000_000_000_000_000_000_010
010_000_000_000_000_000_000_010
010_000_000_000_000_000_000_010
010_000_000_000_000_000_000_010
010_000_000_000_000_000_000_010
010_010_010_010_010_010_010_010
000_000_110_110_110_110_000_000
000_000_110_110_110_110_000_000
000_000_110_110_110_110_000_000
000_000_110_110_110_110_000_000
000_000_110_110_110_110_000_000
000_000_110_110_110_110_000_000
000_000_110_110_110_110_000_000
000_000_110_110_110_110_000_000
001_001_001_001_001_001_001_001
001_001_001_001_001_001_001_001
001_001_001_001_001_001_001_001
001_001_001_001_001_001_001_001
001_001_001_001_001_001_001_001
001_001_001_001_001_001_001_001
001_001_001_001_001_001_001_001
001_001_001_001_001_001_001_001
011_011_011_011_011_011_011_011
011_011_011_011_011_011_011_011
011_011_011_011_011_011_011_011
010_010_010_010_010_010_010_010
010_010_010_010_010_010_010_010
011_011_011_011_011_011_011_011
011_011_011_011_011_011_011_011
011_011_011_011_011_011_011_011
101_101_101_101_101_101_101_101
100_100_100_100_100_100_100_100
100_100_100_100_100_100_100_100
100_100_100_100_100_100_100_100
100_100_100_100_100_100_100_100
100_100_100_100_100_100_100_100
100_100_100_100_100_100_100_100
101_101_101_101_101_101_101_101

// File: map.mem
011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011
011 011 100 100 100 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011
011 011 011 011 011 011 011 011 011 011 101 011 011 011 011 011 011 011 011 011
011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011
011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011
011 011 011 011 011 100 100 100 100 011 011 011 011 011 011 011 011 011 011 011
011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011
011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011
011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011
011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 011 101

// File: render_cases.txt
# name trashCol trashRow robotCol robotRow cursorCol cursorRow probeRow probeColumn rgb
# Object positions are map tiles, column 31 row 15 parks an object off the map
bgEmpty 31 15 31 15 31 15 40 80 0000FF
bgPipe 31 15 31 15 31 15 48 109 00FFFF
bgGoalBorder 31 15 31 15 31 15 63 164 000000
bgLastTile 31 15 31 15 31 15 116 239 FFA500
trashOnly 4 3 31 15 31 15 66 115 00FF00
trashClear 4 3 31 15 31 15 66 112 0000FF
robotOnly 31 15 6 7 31 15 101 129 FF0000
cursorOnPipe 31 15 31 15 2 1 48 100 FFFFFF
cursorClearOnPipe 31 15 31 15 2 1 49 99 00FFFF
cursorOverRobot 31 15 10 4 10 4 74 160 FFFFFF
robotUnderCursor 31 15 10 4 10 4 74 161 FF0000
trashUnderRobot 12 6 12 6 31 15 88 179 FF0000
trashShows 12 6 12 6 31 15 88 180 00FF00
trashClearBoth 12 6 12 6 31 15 88 182 0000FF
rowTenHidden 31 15 0 10 31 15 112 80 0000FF
columnTwentyHidden 31 15 31 15 20 0 40 232 0000FF
offLeft 31 15 31 15 31 15 60 79 000000
offRight 31 15 31 15 31 15 60 240 000000
offAbove 31 15 31 15 31 15 39 100 000000
offBelow 31 15 31 15 31 15 120 100 000000

// File: src.f
tileRenderPkg.sv
tileFetch.sv
overlayLayer.sv
tilePixelOut.sv
tileRenderer.sv
tileRenderer_assertions.sv
tileRendererTb.sv

// File: run.sh
#!/bin/sh
# Build and run the tile renderer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tileRendererTb

./obj_dir/VtileRendererTb | tee sim.log

# The run passes only if the pass message reached the log
grep -q "Everything OK" sim.log
echo "Simulation passed"
